//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mem_subsys_pkg.sv
      - hw/lsu.sv
      - hw/ifu.sv
      - hw/bus_arbiter.sv
      - hw/addr_decoder.sv
      - hw/scratch_ram.sv
      - hw/clint.sv
      - hw/mem_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_mem_subsys.sv

//--- flist.f
+incdir+include
hw/mem_subsys_pkg.sv
hw/lsu.sv
hw/ifu.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/scratch_ram.sv
hw/clint.sv
hw/mem_subsys_top.sv
tb/tb_mem_subsys.sv

//--- hw/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_config.svh"

module addr_decoder (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      req_valid,
    output logic                           req_ready,
    input  wire mem_subsys_pkg::bus_req_t  req,
    output logic                           resp_valid,
    output mem_subsys_pkg::bus_resp_t      resp,
    output logic                           ram_req_valid,
    input  wire logic                      ram_req_ready,
    input  wire logic                      ram_resp_valid,
    input  wire mem_subsys_pkg::bus_resp_t ram_resp,
    output logic                           clint_req_valid,
    input  wire logic                      clint_req_ready,
    input  wire logic                      clint_resp_valid,
    input  wire mem_subsys_pkg::bus_resp_t clint_resp
);
    import mem_subsys_pkg::*;

    localparam bus_addr_u RAM_WIN   = `MS_RAM_BASE;
    localparam bus_addr_u CLINT_WIN = `MS_CLINT_BASE;

    logic is_ram;
    logic is_clint;
    logic err_valid;

    always_comb begin
        is_ram          = (req.addr.ram.region == RAM_WIN.ram.region);
        is_clint        = (req.addr.clint.region == CLINT_WIN.clint.region);
        ram_req_valid   = req_valid && is_ram;
        clint_req_valid = req_valid && is_clint;
        if (is_ram) begin
            req_ready = ram_req_ready;
        end else if (is_clint) begin
            req_ready = clint_req_ready;
        end else begin
            req_ready = !err_valid;
        end
    end

    // only one transfer is in flight, so at most one source is valid
    always_comb begin
        resp_valid = ram_resp_valid || clint_resp_valid || err_valid;
        if (err_valid) begin
            resp = '{rdata: '0, err: 1'b1};
        end else if (clint_resp_valid) begin
            resp = clint_resp;
        end else begin
            resp = ram_resp;
        end
    end

    // unmapped address gets an error one cycle after acceptance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_valid <= 1'b0;
        end else begin
            err_valid <= req_valid && !is_ram && !is_clint && !err_valid;
        end
    end

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire logic                                                        clk,
    input  wire logic                                                        rst_n,
    input  wire logic [mem_subsys_pkg::NUM_MASTERS-1:0]                      m_req_valid,
    input  wire mem_subsys_pkg::bus_req_t [mem_subsys_pkg::NUM_MASTERS-1:0]  m_req,
    output logic [mem_subsys_pkg::NUM_MASTERS-1:0]                           m_req_ready,
    output logic [mem_subsys_pkg::NUM_MASTERS-1:0]                           m_resp_valid,
    output mem_subsys_pkg::bus_resp_t                                        m_resp,
    output logic                                                             s_req_valid,
    input  wire logic                                                        s_req_ready,
    output mem_subsys_pkg::bus_req_t                                         s_req,
    input  wire logic                                                        s_resp_valid,
    input  wire mem_subsys_pkg::bus_resp_t                                   s_resp
);
    import mem_subsys_pkg::*;

    localparam int IDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    // prio names the master that wins the next tie
    logic [IDX_W-1:0] prio;
    logic [IDX_W-1:0] owner;
    logic [IDX_W-1:0] pick;
    logic             locked;

    // walk from the lowest priority up, so the last hit is the winner
    always_comb begin
        pick = prio;
        for (int k = NUM_MASTERS - 1; k >= 0; k--) begin
            if (m_req_valid[(int'(prio) + k) % NUM_MASTERS]) begin
                pick = IDX_W'((int'(prio) + k) % NUM_MASTERS);
            end
        end
    end

    always_comb begin
        s_req_valid  = !locked && m_req_valid[pick];
        s_req        = m_req[pick];
        m_resp       = s_resp;
        m_req_ready  = '0;
        m_resp_valid = '0;
        if (!locked) begin
            m_req_ready[pick] = s_req_ready;
        end else begin
            m_resp_valid[owner] = s_resp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            locked <= 1'b0;
            owner  <= '0;
            prio   <= '0;
        end else if (!locked) begin
            if (s_req_valid && s_req_ready) begin
                locked <= 1'b1;
                owner  <= pick;
                prio   <= IDX_W'((int'(pick) + 1) % NUM_MASTERS);
            end
        end else if (s_resp_valid) begin
            locked <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/clint.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_config.svh"

module clint (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     req_valid,
    output logic                          req_ready,
    input  wire mem_subsys_pkg::bus_req_t req,
    output logic                          resp_valid,
    output mem_subsys_pkg::bus_resp_t     resp
);
    import mem_subsys_pkg::*;

    logic [63:0] mtime;
    logic [31:0] rdata_q;
    logic [2:0]  reg_off;
    logic        accept;

    assign req_ready = !resp_valid;
    assign accept    = req_valid && req_ready;
    assign reg_off   = {req.addr.clint.sel, 2'b00};
    assign resp      = '{rdata: rdata_q, err: 1'b0};

    // mtime holds for the cycle it is written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime      <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
            if (accept && req.we) begin
                if (reg_off == 3'(`MS_CLINT_MTIME_LO)) begin
                    mtime[31:0] <= req.wdata;
                end else begin
                    mtime[63:32] <= req.wdata;
                end
            end else begin
                mtime <= mtime + 64'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (req.we) begin
                rdata_q <= '0;
            end else if (reg_off == 3'(`MS_CLINT_MTIME_HI)) begin
                rdata_q <= mtime[63:32];
            end else begin
                rdata_q <= mtime[31:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/ifu.sv
`timescale 1ns/1ps
`default_nettype none

module ifu (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      fetch_req,
    input  wire logic [31:0]               fetch_pc,
    output logic [31:0]                    fetch_instr,
    output logic                           fetch_done,
    output logic                           fetch_err,
    output logic                           fetch_busy,
    output logic                           req_valid,
    input  wire logic                      req_ready,
    output mem_subsys_pkg::bus_req_t       req,
    input  wire logic                      resp_valid,
    input  wire mem_subsys_pkg::bus_resp_t resp
);
    import mem_subsys_pkg::*;

    logic        pending;
    logic        waiting;
    logic [31:0] pc_q;

    // fetch is always a full word read
    always_comb begin
        req.addr.word = pc_q;
        req.we        = 1'b0;
        req.wdata     = '0;
        req.wstrb     = 4'b1111;
        req.size      = SIZE_WORD;
    end

    assign req_valid  = pending;
    assign fetch_busy = pending | waiting;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            waiting    <= 1'b0;
            fetch_done <= 1'b0;
            fetch_err  <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (!fetch_busy && fetch_req) begin
                pending <= 1'b1;
            end else if (pending && req_ready) begin
                pending <= 1'b0;
                waiting <= 1'b1;
            end else if (waiting && resp_valid) begin
                waiting    <= 1'b0;
                fetch_done <= 1'b1;
                fetch_err  <= resp.err;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch_busy && fetch_req) begin
            pc_q <= fetch_pc;
        end
        if (waiting && resp_valid) begin
            fetch_instr <= resp.rdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         lsu_req,
    input  wire logic                         lsu_we,
    input  wire logic                         lsu_sign,
    input  wire mem_subsys_pkg::access_size_e lsu_size,
    input  wire logic [31:0]                  lsu_addr,
    input  wire logic [31:0]                  lsu_wdata,
    output logic [31:0]                       lsu_rdata,
    output logic                              lsu_done,
    output logic                              lsu_err,
    output logic                              lsu_busy,
    output logic                              req_valid,
    input  wire logic                         req_ready,
    output mem_subsys_pkg::bus_req_t          req,
    input  wire logic                         resp_valid,
    input  wire mem_subsys_pkg::bus_resp_t    resp
);
    import mem_subsys_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e      state;
    bus_req_t    req_q;
    logic        sign_q;
    logic [3:0]  strb;
    logic [31:0] shifted;
    logic [31:0] ext;

    // byte lanes touched by the access
    always_comb begin
        case (lsu_size)
            SIZE_BYTE: strb = 4'b0001 << lsu_addr[1:0];
            SIZE_HALF: strb = lsu_addr[1] ? 4'b1100 : 4'b0011;
            SIZE_WORD: strb = 4'b1111;
            default:   strb = 4'b0000;
        endcase
    end

    // move the addressed lanes down to bit 0, then extend
    always_comb begin
        shifted = resp.rdata >> {req_q.addr.word[1:0], 3'b000};
        case (req_q.size)
            SIZE_BYTE: ext = {{24{shifted[7] & sign_q}}, shifted[7:0]};
            SIZE_HALF: ext = {{16{shifted[15] & sign_q}}, shifted[15:0]};
            default:   ext = shifted;
        endcase
    end

    assign req_valid = (state == ST_REQ);
    assign lsu_busy  = (state != ST_IDLE);
    assign req       = req_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            lsu_done <= 1'b0;
            lsu_err  <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (lsu_req) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (req_ready) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (resp_valid) begin
                        state    <= ST_IDLE;
                        lsu_done <= 1'b1;
                        lsu_err  <= resp.err;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && lsu_req) begin
            req_q.addr.word <= lsu_addr;
            req_q.we        <= lsu_we;
            req_q.wdata     <= lsu_wdata << {lsu_addr[1:0], 3'b000};
            req_q.wstrb     <= strb;
            req_q.size      <= lsu_size;
            sign_q          <= lsu_sign;
        end
        if (state == ST_WAIT && resp_valid) begin
            lsu_rdata <= ext;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_subsys_pkg.sv
`default_nettype none

`include "mem_subsys_config.svh"

package mem_subsys_pkg;

    localparam int NUM_MASTERS = 2;
    localparam int RAM_IDX_W = $clog2(`MS_RAM_WORDS);

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // ram view of an address
    typedef struct packed {
        logic [31-RAM_IDX_W-2:0] region;
        logic [RAM_IDX_W-1:0]    index;
        logic [1:0]              offset;
    } ram_addr_t;

    // clint view, one select bit picks the mtime half
    typedef struct packed {
        logic [28:0] region;
        logic        sel;
        logic [1:0]  offset;
    } clint_addr_t;

    typedef union packed {
        logic [31:0] word;
        ram_addr_t   ram;
        clint_addr_t clint;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u    addr;
        logic         we;
        logic [31:0]  wdata;
        logic [3:0]   wstrb;
        access_size_e size;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } bus_resp_t;

endpackage

`default_nettype wire

//--- hw/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         fetch_req,
    input  wire logic [31:0]                  fetch_pc,
    output logic [31:0]                       fetch_instr,
    output logic                              fetch_done,
    output logic                              fetch_err,
    output logic                              fetch_busy,
    input  wire logic                         lsu_req,
    input  wire logic                         lsu_we,
    input  wire logic                         lsu_sign,
    input  wire mem_subsys_pkg::access_size_e lsu_size,
    input  wire logic [31:0]                  lsu_addr,
    input  wire logic [31:0]                  lsu_wdata,
    output logic [31:0]                       lsu_rdata,
    output logic                              lsu_done,
    output logic                              lsu_err,
    output logic                              lsu_busy
);
    import mem_subsys_pkg::*;

    // master side, index 0 is fetch and 1 is load/store
    wire logic [NUM_MASTERS-1:0]     m_req_valid;
    wire logic [NUM_MASTERS-1:0]     m_req_ready;
    wire logic [NUM_MASTERS-1:0]     m_resp_valid;
    wire bus_req_t [NUM_MASTERS-1:0] m_req;
    wire bus_resp_t                  m_resp;

    // shared bus and slaves
    wire logic      s_req_valid;
    wire logic      s_req_ready;
    wire logic      s_resp_valid;
    wire bus_req_t  s_req;
    wire bus_resp_t s_resp;
    wire logic      ram_req_valid;
    wire logic      ram_req_ready;
    wire logic      ram_resp_valid;
    wire bus_resp_t ram_resp;
    wire logic      clint_req_valid;
    wire logic      clint_req_ready;
    wire logic      clint_resp_valid;
    wire bus_resp_t clint_resp;

    ifu ifu_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_done  (fetch_done),
        .fetch_err   (fetch_err),
        .fetch_busy  (fetch_busy),
        .req_valid   (m_req_valid[0]),
        .req_ready   (m_req_ready[0]),
        .req         (m_req[0]),
        .resp_valid  (m_resp_valid[0]),
        .resp        (m_resp)
    );

    lsu lsu_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu_req    (lsu_req),
        .lsu_we     (lsu_we),
        .lsu_sign   (lsu_sign),
        .lsu_size   (lsu_size),
        .lsu_addr   (lsu_addr),
        .lsu_wdata  (lsu_wdata),
        .lsu_rdata  (lsu_rdata),
        .lsu_done   (lsu_done),
        .lsu_err    (lsu_err),
        .lsu_busy   (lsu_busy),
        .req_valid  (m_req_valid[1]),
        .req_ready  (m_req_ready[1]),
        .req        (m_req[1]),
        .resp_valid (m_resp_valid[1]),
        .resp       (m_resp)
    );

    bus_arbiter bus_arbiter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .m_req_valid  (m_req_valid),
        .m_req        (m_req),
        .m_req_ready  (m_req_ready),
        .m_resp_valid (m_resp_valid),
        .m_resp       (m_resp),
        .s_req_valid  (s_req_valid),
        .s_req_ready  (s_req_ready),
        .s_req        (s_req),
        .s_resp_valid (s_resp_valid),
        .s_resp       (s_resp)
    );

    addr_decoder addr_decoder_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (s_req_valid),
        .req_ready        (s_req_ready),
        .req              (s_req),
        .resp_valid       (s_resp_valid),
        .resp             (s_resp),
        .ram_req_valid    (ram_req_valid),
        .ram_req_ready    (ram_req_ready),
        .ram_resp_valid   (ram_resp_valid),
        .ram_resp         (ram_resp),
        .clint_req_valid  (clint_req_valid),
        .clint_req_ready  (clint_req_ready),
        .clint_resp_valid (clint_resp_valid),
        .clint_resp       (clint_resp)
    );

    scratch_ram scratch_ram_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (ram_req_valid),
        .req_ready  (ram_req_ready),
        .req        (s_req),
        .resp_valid (ram_resp_valid),
        .resp       (ram_resp)
    );

    clint clint_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (clint_req_valid),
        .req_ready  (clint_req_ready),
        .req        (s_req),
        .resp_valid (clint_resp_valid),
        .resp       (clint_resp)
    );

endmodule

`default_nettype wire

//--- hw/scratch_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_config.svh"

module scratch_ram (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     req_valid,
    output logic                          req_ready,
    input  wire mem_subsys_pkg::bus_req_t req,
    output logic                          resp_valid,
    output mem_subsys_pkg::bus_resp_t     resp
);
    import mem_subsys_pkg::*;

    logic [31:0] mem [`MS_RAM_WORDS];
    logic [31:0] rdata_q;
    logic        accept;

    assign req_ready = !resp_valid;
    assign accept    = req_valid && req_ready;
    assign resp      = '{rdata: rdata_q, err: 1'b0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    // writes answer with zero, reads with the stored word
    always_ff @(posedge clk) begin
        if (accept) begin
            if (req.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.wstrb[b]) begin
                        mem[req.addr.ram.index][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
                rdata_q <= '0;
            end else begin
                rdata_q <= mem[req.addr.ram.index];
            end
        end
    end

endmodule

`default_nettype wire

//--- include/mem_subsys_config.svh
`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// address map
`define MS_RAM_BASE       32'h8000_0000
`define MS_CLINT_BASE     32'ha000_0048

// scratch ram depth in 32-bit words
`define MS_RAM_WORDS      256

// byte offsets of the mtime halves inside the clint window
`define MS_CLINT_MTIME_LO 0
`define MS_CLINT_MTIME_HI 4

`endif

//--- tb/tb_mem_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_subsys_config.svh"

module tb_mem_subsys;
    import mem_subsys_pkg::*;

    localparam int RAM_BYTES = `MS_RAM_WORDS * 4;
    localparam int N_INIT    = `MS_RAM_WORDS;
    localparam int N_WORD    = 40;
    localparam int N_SUB     = 300;
    localparam int N_FETCH   = 40;
    localparam int N_CONC    = 40;
    localparam int N_ERR     = 12;
    localparam int N_TIME    = 4;
    localparam int NUM_OPS   = N_INIT + 2 * N_WORD + N_SUB + N_FETCH + 3 * N_CONC
                             + 4 * N_ERR + 6 * N_TIME;
    localparam int CYCLE_LIMIT = 40 * NUM_OPS;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         fetch_req;
    logic [31:0]  fetch_pc;
    logic [31:0]  fetch_instr;
    logic         fetch_done;
    logic         fetch_err;
    logic         fetch_busy;
    logic         lsu_req;
    logic         lsu_we;
    logic         lsu_sign;
    access_size_e lsu_size;
    logic [31:0]  lsu_addr;
    logic [31:0]  lsu_wdata;
    logic [31:0]  lsu_rdata;
    logic         lsu_done;
    logic         lsu_err;
    logic         lsu_busy;

    integer       seed = 32'h1490;
    int           cycles = 0;
    // byte image of the scratch RAM
    logic [7:0]   model [RAM_BYTES];

    mem_subsys_top mem_subsys_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fetch_done  (fetch_done),
        .fetch_err   (fetch_err),
        .fetch_busy  (fetch_busy),
        .lsu_req     (lsu_req),
        .lsu_we      (lsu_we),
        .lsu_sign    (lsu_sign),
        .lsu_size    (lsu_size),
        .lsu_addr    (lsu_addr),
        .lsu_wdata   (lsu_wdata),
        .lsu_rdata   (lsu_rdata),
        .lsu_done    (lsu_done),
        .lsu_err     (lsu_err),
        .lsu_busy    (lsu_busy)
    );

    always #4 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            stop_on_error($sformatf("timeout: no completion within %0d cycles", CYCLE_LIMIT));
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic access_size_e rand_size();
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0:    return SIZE_BYTE;
            2'd1:    return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // random RAM address aligned to the access size
    function automatic logic [31:0] ram_addr(input access_size_e size);
        logic [31:0] off;
        off = next_rand() & (RAM_BYTES - 1);
        if (size == SIZE_HALF) off[0] = 1'b0;
        if (size == SIZE_WORD) off[1:0] = 2'b00;
        return `MS_RAM_BASE + off;
    endfunction

    function automatic int size_bytes(input access_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // little endian, byte k of the access sits at address + k
    function automatic logic [31:0] exp_load(input logic [31:0] addr, input access_size_e size,
                                             input logic sign);
        int          a;
        logic [31:0] v;
        a = int'(addr & (RAM_BYTES - 1));
        v = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            v[8*k +: 8] = model[a + k];
        end
        if (sign && size == SIZE_BYTE && v[7]) v[31:8] = '1;
        if (sign && size == SIZE_HALF && v[15]) v[31:16] = '1;
        return v;
    endfunction

    function automatic void update_model(input logic [31:0] addr, input access_size_e size,
                                         input logic [31:0] data);
        int a;
        a = int'(addr & (RAM_BYTES - 1));
        for (int k = 0; k < size_bytes(size); k++) begin
            model[a + k] = data[8*k +: 8];
        end
    endfunction

    task automatic check_load(input logic [31:0] exp_data, input logic [31:0] got_data,
                              input logic exp_err, input logic got_err, input bit cmp_data);
        if (got_err !== exp_err) begin
            stop_on_error($sformatf("mismatch lsu_err: expected %h got %h", exp_err, got_err));
        end else if (cmp_data && got_data !== exp_data) begin
            stop_on_error($sformatf("mismatch lsu_rdata: expected %h got %h",
                                    exp_data, got_data));
        end
    endtask

    task automatic check_fetch(input logic [31:0] exp_instr, input logic [31:0] got_instr,
                               input logic exp_err, input logic got_err);
        if (got_err !== exp_err) begin
            stop_on_error($sformatf("mismatch fetch_err: expected %h got %h", exp_err, got_err));
        end else if (!exp_err && got_instr !== exp_instr) begin
            stop_on_error($sformatf("mismatch fetch_instr: expected %h got %h",
                                    exp_instr, got_instr));
        end
    endtask

    task automatic check_time(input logic [63:0] low, input logic [63:0] high,
                              input logic [63:0] got);
        if (got < low || got >= high) begin
            stop_on_error($sformatf("mismatch mtime: got %h expected from %h up to below %h",
                                    got, low, high));
        end
    endtask

    task automatic check_busy(input string name, input logic exp_busy, input logic got_busy);
        if (got_busy !== exp_busy) begin
            stop_on_error($sformatf("mismatch %s: expected %h got %h", name, exp_busy,
                                    got_busy));
        end
    endtask

    // called at 1 ns after a rising edge, returns at the same point after lsu_done
    task automatic lsu_op(input logic we, input logic sign, input access_size_e size,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
        check_busy("lsu_busy", 1'b0, lsu_busy);
        lsu_req   = 1'b1;
        lsu_we    = we;
        lsu_sign  = sign;
        lsu_size  = size;
        lsu_addr  = addr;
        lsu_wdata = wdata;
        @(posedge clk);
        #1;
        lsu_req = 1'b0;
        // busy stays up while waiting for the grant and the response
        while (lsu_done !== 1'b1) begin
            check_busy("lsu_busy", 1'b1, lsu_busy);
            @(posedge clk);
            #1;
        end
        check_busy("lsu_busy", 1'b0, lsu_busy);
        rdata = lsu_rdata;
        err   = lsu_err;
    endtask

    task automatic fetch_op(input logic [31:0] pc, output logic [31:0] instr, output logic err);
        check_busy("fetch_busy", 1'b0, fetch_busy);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
        while (fetch_done !== 1'b1) begin
            check_busy("fetch_busy", 1'b1, fetch_busy);
            @(posedge clk);
            #1;
        end
        check_busy("fetch_busy", 1'b0, fetch_busy);
        instr = fetch_instr;
        err   = fetch_err;
    endtask

    task automatic do_store(input access_size_e size, input logic [31:0] addr,
                            input logic [31:0] data);
        logic [31:0] rd;
        logic        er;
        lsu_op(1'b1, 1'b0, size, addr, data, rd, er);
        // a RAM write answers with a zero word
        check_load(32'h0, rd, 1'b0, er, 1'b1);
        update_model(addr, size, data);
    endtask

    task automatic do_load(input access_size_e size, input logic sign, input logic [31:0] addr);
        logic [31:0] rd;
        logic        er;
        lsu_op(1'b0, sign, size, addr, '0, rd, er);
        check_load(exp_load(addr, size, sign), rd, 1'b0, er, 1'b1);
    endtask

    task automatic read_mtime(output logic [63:0] t);
        logic [31:0] hi;
        logic [31:0] lo;
        logic        er;
        lsu_op(1'b0, 1'b0, SIZE_WORD, `MS_CLINT_BASE + `MS_CLINT_MTIME_HI, '0, hi, er);
        check_load('0, hi, 1'b0, er, 1'b0);
        lsu_op(1'b0, 1'b0, SIZE_WORD, `MS_CLINT_BASE + `MS_CLINT_MTIME_LO, '0, lo, er);
        check_load('0, lo, 1'b0, er, 1'b0);
        t = {hi, lo};
    endtask

    logic [31:0]  addr;
    logic [31:0]  data;
    logic [31:0]  rd;
    logic [31:0]  f_instr;
    logic [31:0]  l_data;
    logic [31:0]  exp_f;
    logic [31:0]  exp_l;
    logic         er;
    logic         f_err;
    logic         l_err;
    logic         we;
    logic         sign;
    access_size_e size;
    logic [63:0]  w_time;
    logic [63:0]  t1;
    logic [63:0]  t2;
    int           fidx;

    initial begin
        rst_n     = 1'b0;
        fetch_req = 1'b0;
        fetch_pc  = '0;
        lsu_req   = 1'b0;
        lsu_we    = 1'b0;
        lsu_sign  = 1'b0;
        lsu_size  = SIZE_WORD;
        lsu_addr  = '0;
        lsu_wdata = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // RAM starts undefined, so fill it first
        for (int i = 0; i < N_INIT; i++) begin
            do_store(SIZE_WORD, `MS_RAM_BASE + 4 * i, next_rand());
        end

        for (int i = 0; i < N_WORD; i++) begin
            addr = ram_addr(SIZE_WORD);
            do_store(SIZE_WORD, addr, next_rand());
            do_load(SIZE_WORD, 1'b0, addr);
        end

        for (int i = 0; i < N_SUB; i++) begin
            size = rand_size();
            addr = ram_addr(size);
            data = next_rand();
            if (data[31]) begin
                do_store(size, addr, next_rand());
            end else begin
                do_load(size, data[30], addr);
            end
        end

        for (int i = 0; i < N_FETCH; i++) begin
            addr = ram_addr(SIZE_WORD);
            fetch_op(addr, f_instr, f_err);
            check_fetch(exp_load(addr, SIZE_WORD, 1'b0), f_instr, 1'b0, f_err);
        end

        // fetch and load/store in the same cycle, stores avoid the fetched word
        for (int i = 0; i < N_CONC; i++) begin
            fidx  = int'(next_rand() & (`MS_RAM_WORDS - 1));
            exp_f = exp_load(`MS_RAM_BASE + 4 * fidx, SIZE_WORD, 1'b0);
            size  = rand_size();
            data  = next_rand();
            we    = data[0];
            sign  = data[1];
            // the master served last loses the tie, so a lone access picks the order
            if (data[2]) begin
                do_load(SIZE_WORD, 1'b0, ram_addr(SIZE_WORD));
            end else begin
                addr = ram_addr(SIZE_WORD);
                fetch_op(addr, f_instr, f_err);
                check_fetch(exp_load(addr, SIZE_WORD, 1'b0), f_instr, 1'b0, f_err);
            end
            addr  = ram_addr(size);
            while (we && ((addr - `MS_RAM_BASE) >> 2) == fidx) begin
                addr = ram_addr(size);
            end
            exp_l = we ? 32'h0 : exp_load(addr, size, sign);
            fork
                fetch_op(`MS_RAM_BASE + 4 * fidx, f_instr, f_err);
                lsu_op(we, sign, size, addr, data, l_data, l_err);
            join
            check_fetch(exp_f, f_instr, 1'b0, f_err);
            check_load(exp_l, l_data, 1'b0, l_err, 1'b1);
            if (we) update_model(addr, size, data);
        end

        // unmapped addresses below the RAM window
        for (int i = 0; i < N_ERR; i++) begin
            addr = 32'h1000_0000 | (next_rand() & 32'h0fff_fffc);
            lsu_op(1'b0, 1'b0, SIZE_WORD, addr, '0, rd, er);
            check_load('0, rd, 1'b1, er, 1'b0);
            lsu_op(1'b1, 1'b0, SIZE_WORD, addr, next_rand(), rd, er);
            check_load('0, rd, 1'b1, er, 1'b0);
            do_load(SIZE_WORD, 1'b0, `MS_RAM_BASE + (addr & (RAM_BYTES - 1)));
            fetch_op(addr, f_instr, f_err);
            check_fetch('0, f_instr, 1'b1, f_err);
        end

        for (int i = 0; i < N_TIME; i++) begin
            w_time = {next_rand() & 32'h7fff_ffff, next_rand() & 32'h0fff_ffff};
            lsu_op(1'b1, 1'b0, SIZE_WORD, `MS_CLINT_BASE + `MS_CLINT_MTIME_HI,
                   w_time[63:32], rd, er);
            check_load('0, rd, 1'b0, er, 1'b0);
            lsu_op(1'b1, 1'b0, SIZE_WORD, `MS_CLINT_BASE + `MS_CLINT_MTIME_LO,
                   w_time[31:0], rd, er);
            check_load('0, rd, 1'b0, er, 1'b0);
            read_mtime(t1);
            check_time(w_time, w_time + 64'(CYCLE_LIMIT), t1);
            read_mtime(t2);
            check_time(t1, w_time + 64'(CYCLE_LIMIT), t2);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
